//--- dv/tbPaletteBus.sv
// Palette bus testbench with a line buffer shadow model and a mixer reference
`timescale 1ns/1ps

module tbPaletteBus;
	import videoPkg::*;

	// Covers reset, buffer passes, mixer and CPU phases, three kick gaps and the expiry
	localparam int timeoutCycles = 6000;

	logic         CLK_1MB;
	logic         rstN;
	logic [23:0]  pbus;
	logic [7:0]   fixd;
	logic         pck1, pck2, chbl, bnkb;
	logic [3:0]   gad, gbd, we, ck;
	logic         tms0, s1h1, ld1, ld2, ss1, ss2;
	logic         a23i, a22i, ldsN, rw, asN;
	logic [21:17] addrU;
	logic [12:1]  addrL;
	logic [11:0]  pa;
	logic         haltN, resetN;

	// Expected line buffer contents
	lbEntry shadow [lbCount][lbDepth];
	int cycles = 0;

	paletteBus u_paletteBus (.*);

	initial begin
		CLK_1MB = 1'b0;
		forever #4 CLK_1MB = ~CLK_1MB;
	end

	// Run limit
	always @(posedge CLK_1MB) begin
		cycles <= cycles + 1;
		if (cycles >= timeoutCycles) begin
			$display("TEST FAIL");
			$fatal(1, "Timeout, the run did not finish within %0d cycles", timeoutCycles);
		end
	end

	task automatic checkVal(input string name, input logic [11:0] got, input logic [11:0] exp);
		assert (got === exp) else begin
			$display("CHECK FAILED %s got 0x%0h expected 0x%0h", name, got, exp);
			$display("TEST FAIL");
			$fatal(1, "Wrong value on %s", name);
		end
	endtask

	// Color with a one in three chance of transparent
	function automatic logic [3:0] randNibble();
		if ($urandom_range(0, 2) == 0)
			return 4'h0;
		return 4'($urandom_range(1, 15));
	endfunction

	// Expected video address from the priority rules
	function automatic logic [11:0] expectMix(input logic blank, input logic [7:0] fix,
			input logic [3:0] fixPal, input logic [1:0] sel, input logic [7:0] a);
		logic [3:0] fixColor;
		int bufIdx;
		fixColor = sel[0] ? fix[7:4] : fix[3:0];
		// {tms0, s1h1} of 00, 01, 10, 11 shows buffer 1, 0, 3, 2
		bufIdx = (sel[1] ? 2 : 0) + (sel[0] ? 0 : 1);
		if (blank)
			return 12'h000;
		if (fixColor != 4'h0)
			return {4'h0, fixPal, fixColor};
		return shadow[bufIdx][a];
	endfunction

	// Render or display mode for the pair holding buffer b
	task automatic setDisplay(input int b, input logic display);
		if (b < 2)
			ss1 <= display;
		else
			ss2 <= display;
	endtask

	// Draw 16 pixels from start into buffer b
	task automatic render(input int b, input logic [7:0] start, input bit allowZero);
		logic [7:0] palNum;
		logic [7:0] a;
		logic [3:0] c;
		palNum = 8'($urandom);
		@(posedge CLK_1MB);
		setDisplay(b, 1'b0);
		ld1 <= 1'b1;
		ld2 <= 1'b1;
		pck2 <= 1'b1;
		pbus <= {palNum, start, start};
		for (int i = 0; i < 16; i++) begin
			c = allowZero ? randNibble() : 4'($urandom_range(1, 15));
			@(posedge CLK_1MB);
			ld1 <= 1'b0;
			ld2 <= 1'b0;
			pck2 <= 1'b0;
			we <= 4'b1 << b;
			ck <= 4'b1 << b;
			gad <= c;
			gbd <= c;
			// Transparent pixels keep the old word
			a = start + 8'(i);
			if (c != 4'h0)
				shadow[b][a] = {palNum, c};
		end
		@(posedge CLK_1MB);
		we <= '0;
		ck <= '0;
	endtask

	// Step through 16 pixels in display mode and clear them if asked
	task automatic readBack(input int b, input logic [7:0] start, input bit clear);
		logic [11:0] expq [16];
		logic [7:0] a;
		for (int i = 0; i < 16; i++) begin
			a = start + 8'(i);
			expq[i] = shadow[b][a];
			if (clear)
				shadow[b][a] = '0;
		end
		@(posedge CLK_1MB);
		setDisplay(b, 1'b1);
		tms0 <= (b >= 2);
		s1h1 <= (b % 2 == 0);
		fixd <= 8'h00;
		chbl <= 1'b0;
		ld1 <= 1'b1;
		ld2 <= 1'b1;
		pbus <= {8'h00, start, start};
		@(posedge CLK_1MB);
		ld1 <= 1'b0;
		ld2 <= 1'b0;
		ck <= 4'b1 << b;
		we <= clear ? (4'b1 << b) : 4'b0;
		// Pixel at an address reaches pa two edges later
		for (int t = 0; t <= 16; t++) begin
			@(posedge CLK_1MB);
			if (t == 15) begin
				ck <= '0;
				we <= '0;
			end
			@(negedge CLK_1MB);
			if (t >= 1)
				checkVal("pa", pa, expq[t-1]);
		end
	endtask

	// Random fix, select and blanking over a steady sprite readout
	task automatic mixTest(input logic [7:0] start);
		logic [7:0] dFixd;
		logic [7:0] fixReg;
		logic [3:0] dFixPal;
		logic [3:0] fixPal;
		logic [1:0] dSel;
		logic [11:0] expPa;
		logic dPck1;
		logic dChbl;
		dFixd = 8'h00;
		dPck1 = 1'b1;
		dFixPal = 4'($urandom);
		dSel = 2'b01;
		dChbl = 1'b0;
		fixReg = 8'h00;
		fixPal = 4'h0;
		for (int t = 0; t <= 48; t++) begin
			@(posedge CLK_1MB);
			if (t == 0) begin
				ss1 <= 1'b1;
				ss2 <= 1'b1;
				ld1 <= 1'b1;
				ld2 <= 1'b1;
			end else begin
				ld1 <= 1'b0;
				ld2 <= 1'b0;
				// Model registers take what this edge sampled
				expPa = expectMix(dChbl, fixReg, fixPal, dSel, start);
				fixReg = dFixd;
				if (dPck1)
					fixPal = dFixPal;
				dFixd = {randNibble(), randNibble()};
				dPck1 = ($urandom_range(0, 3) == 0);
				dFixPal = 4'($urandom);
				dSel = 2'($urandom);
				dChbl = ($urandom_range(0, 4) == 0);
			end
			pbus <= {4'h0, dFixPal, start, start};
			fixd <= dFixd;
			pck1 <= dPck1;
			{tms0, s1h1} <= dSel;
			chbl <= dChbl;
			@(negedge CLK_1MB);
			// Readout settles two edges after the load
			if (t >= 3)
				checkVal("pa", pa, expPa);
		end
	endtask

	// CPU palette access and release
	task automatic cpuTest();
		logic [3:0] fp;
		logic [12:1] adr;
		fp = 4'($urandom);
		@(posedge CLK_1MB);
		pck1 <= 1'b1;
		pbus <= {4'h0, fp, 16'h0000};
		fixd <= 8'hFF;
		chbl <= 1'b0;
		for (int i = 0; i < 8; i++) begin
			@(posedge CLK_1MB);
			if (i == 0) begin
				pck1 <= 1'b0;
				asN <= 1'b0;
				a23i <= 1'b0;
				a22i <= 1'b1;
			end
			adr = 12'($urandom);
			addrL <= adr;
			@(negedge CLK_1MB);
			// Override follows addrL without a register
			if (i >= 1)
				checkVal("pa", pa, adr);
		end
		@(posedge CLK_1MB);
		asN <= 1'b1;
		@(posedge CLK_1MB);
		asN <= 1'b0;
		{a23i, a22i} <= 2'($urandom_range(2, 3));
		@(posedge CLK_1MB);
		asN <= 1'b1;
		@(negedge CLK_1MB);
		checkVal("pa", pa, {4'h0, fp, 4'hF});
	endtask

	// One CPU byte write into the watchdog region
	task automatic kick();
		@(posedge CLK_1MB);
		bnkb <= 1'b0;
		rw <= 1'b0;
		ldsN <= 1'b0;
		a23i <= 1'b0;
		a22i <= 1'b0;
		addrU <= wdKickAddr;
		@(posedge CLK_1MB);
		rw <= 1'b1;
		ldsN <= 1'b1;
	endtask

	// Quiet cycles with resetN held high
	task automatic idleWatch(input int n, input bit strobes);
		for (int i = 0; i < n; i++) begin
			@(posedge CLK_1MB);
			bnkb <= strobes && ($urandom_range(0, 7) == 0);
			@(negedge CLK_1MB);
			checkVal("resetN", 12'(resetN), 12'h001);
			checkVal("haltN", 12'(haltN), 12'h001);
		end
	endtask

	task automatic watchdogTest();
		int lowCycles;
		lowCycles = 0;
		kick();
		for (int k = 0; k < 3; k++) begin
			idleWatch(100 + int'($urandom_range(0, 799)), 1'b1);
			kick();
		end
		// Past the limit the watchdog waits for the frame strobe
		idleWatch(wdLimit + 8, 1'b0);
		@(posedge CLK_1MB);
		bnkb <= 1'b1;
		@(negedge CLK_1MB);
		checkVal("resetN", 12'(resetN), 12'h001);
		@(posedge CLK_1MB);
		bnkb <= 1'b0;
		@(negedge CLK_1MB);
		checkVal("resetN", 12'(resetN), 12'h000);
		while (resetN === 1'b0) begin
			checkVal("haltN", 12'(haltN), 12'h000);
			lowCycles++;
			@(negedge CLK_1MB);
		end
		checkVal("resetN", 12'(resetN), 12'h001);
		checkVal("haltN", 12'(haltN), 12'h001);
		checkVal("resetN low cycles", 12'(lowCycles), 12'(wdPulse));
	endtask

	initial begin
		logic [7:0] start;
		void'($urandom(42946));
		rstN = 1'b0;
		pbus = '0;
		fixd = '0;
		{pck1, pck2, chbl, bnkb} = '0;
		{gad, gbd, we, ck} = '0;
		{tms0, s1h1, ld1, ld2, ss1, ss2} = '0;
		{a23i, a22i} = '0;
		{ldsN, rw, asN} = 3'b111;
		addrU = '0;
		addrL = '0;
		repeat (16) @(posedge CLK_1MB);
		rstN <= 1'b1;
		kick();
		// Full draw, overdraw with holes, then clear and read again
		for (int b = 0; b < lbCount; b++) begin
			start = 8'($urandom);
			render(b, start, 1'b0);
			render(b, start, 1'b1);
			readBack(b, start, 1'b1);
			readBack(b, start, 1'b0);
		end
		start = 8'($urandom);
		for (int b = 0; b < lbCount; b++)
			render(b, start, 1'b0);
		mixTest(start);
		cpuTest();
		watchdogTest();
		$display("TEST PASS");
		$finish;
	end

endmodule

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module tbPaletteBus -f src.f
out=$(./obj_dir/VtbPaletteBus 2>&1) || true
echo "$out"
if echo "$out" | grep -qx "TEST PASS"; then
	exit 0
fi
exit 1

//--- src.f
verilog/videoPkg.sv
verilog/lineBufIf.sv
verilog/lineBuffer.sv
verilog/pixelMixer.sv
verilog/watchdog.sv
verilog/paletteBus.sv
dv/tbPaletteBus.sv

//--- verilog/lineBufIf.sv
// Line buffer control interface carrying strobes, pixel data and load address
`timescale 1ns/1ps

interface lineBufIf;
	import videoPkg::*;

	// Address counter advance
	logic ck;
	// Pixel write
	logic we;
	// Start address load
	logic ld;
	// High in display mode, low while rendering
	logic ss;
	// Sprite palette latch
	logic palLd;

	// Sprite pixel color
	logic [colorW-1:0] color;
	// Sprite palette number
	logic [palW-1:0] pal;
	// Start address from the pixel bus
	logic [lbAddrW-1:0] loadAddr;

	// Driver side at the top level
	modport ctrl (output ck, we, ld, ss, palLd, color, pal, loadAddr);

	// Line buffer side
	modport buffer (input ck, we, ld, ss, palLd, color, pal, loadAddr);

endinterface

//--- verilog/lineBuffer.sv
// Sprite line buffer that draws one scanline and clears each pixel as it is shown
`timescale 1ns/1ps

module lineBuffer (
	input  logic             CLK_1MB,
	input  logic             rstN,
	lineBufIf.buffer         lb,
	output videoPkg::lbEntry readout
);
	import videoPkg::*;

	// One word per pixel of the line
	lbEntry mem [lbDepth];

	// Pixel address counter
	logic [lbAddrW-1:0] addr;

	// Palette of the sprite being drawn
	logic [palW-1:0] palLatch;

	// Word and enable for this cycle's write
	lbEntry wrWord;
	logic   wrEn;

	// Address counter
	// Load has priority over advance
	always_ff @(posedge CLK_1MB or negedge rstN) begin
		if (!rstN) begin
			addr <= '0;
		end else if (lb.ld) begin
			addr <= lb.loadAddr;
		end else if (lb.ck) begin
			// Wraps at the end of the line
			addr <= addr + 1'b1;
		end
	end

	// Sprite palette latch
	always_ff @(posedge CLK_1MB) begin
		if (lb.palLd) begin
			palLatch <= lb.pal;
		end
	end

	// Write word select
	always_comb begin
		if (lb.ss) begin
			// Display mode
			// Shown pixel is erased for the next render pass
			wrWord = '0;
			wrEn   = lb.we;
		end else begin
			// Render mode
			wrWord.pal   = palLatch;
			wrWord.color = lb.color;
			// Transparent pixels keep what is underneath
			wrEn         = lb.we && (lb.color != '0);
		end
	end

	// Storage and registered readout
	// Read sees the old word when a write hits the same address
	always_ff @(posedge CLK_1MB) begin
		if (wrEn) begin
			mem[addr] <= wrWord;
		end
		readout <= mem[addr];
	end

endmodule

//--- verilog/paletteBus.sv
// Palette bus top level with four sprite line buffers, pixel mixer and watchdog
`timescale 1ns/1ps

module paletteBus (
	input  logic         CLK_1MB,
	input  logic         rstN,
	input  logic [23:0]  pbus,
	input  logic [7:0]   fixd,
	input  logic         pck1,
	input  logic         pck2,
	input  logic         chbl,
	input  logic         bnkb,
	input  logic [3:0]   gad,
	input  logic [3:0]   gbd,
	input  logic [3:0]   we,
	input  logic [3:0]   ck,
	input  logic         tms0,
	input  logic         ld1,
	input  logic         ld2,
	input  logic         ss1,
	input  logic         ss2,
	input  logic         s1h1,
	input  logic         a23i,
	input  logic         a22i,
	input  logic         ldsN,
	input  logic         rw,
	input  logic         asN,
	input  logic [21:17] addrU,
	input  logic [12:1]  addrL,
	output logic [11:0]  pa,
	output logic         haltN,
	output logic         resetN
);
	import videoPkg::*;

	// Registered readout of each buffer
	lbEntry readouts [lbCount];

	// Buffers 0 and 1 are the bottom pair, 2 and 3 the top pair
	// Even buffers take the left pixel bus, odd ones the right
	for (genvar i = 0; i < lbCount; i++) begin : gLane
		lineBufIf lbIf ();

		// Per-buffer strobes
		assign lbIf.ck    = ck[i];
		assign lbIf.we    = we[i];
		assign lbIf.ld    = (i < 2) ? ld1 : ld2;
		assign lbIf.ss    = (i < 2) ? ss1 : ss2;
		// Shared sprite palette
		assign lbIf.palLd = pck2;
		assign lbIf.pal   = pbus[23:16];
		// Pixel and start address by side
		assign lbIf.color    = (i % 2 == 0) ? gad : gbd;
		assign lbIf.loadAddr = pbus[(i % 2) * lbAddrW +: lbAddrW];

		lineBuffer uLineBuf (
			.CLK_1MB (CLK_1MB),
			.rstN    (rstN),
			.lb      (lbIf.buffer),
			.readout (readouts[i])
		);
	end

	pixelMixer uMixer (
		.CLK_1MB    (CLK_1MB),
		.rstN       (rstN),
		.fixd       (fixd),
		.pck1       (pck1),
		.pbusFixPal (pbus[19:16]),
		.s1h1       (s1h1),
		.tms0       (tms0),
		.chbl       (chbl),
		.readouts   (readouts),
		.asN        (asN),
		.a23i       (a23i),
		.a22i       (a22i),
		.addrL      (addrL),
		.pa         (pa)
	);

	watchdog uWatchdog (
		.CLK_1MB (CLK_1MB),
		.rstN    (rstN),
		.ldsN    (ldsN),
		.rw      (rw),
		.a23i    (a23i),
		.a22i    (a22i),
		.addrU   (addrU),
		.bnkb    (bnkb),
		.resetN  (resetN)
	);

	// CPU halt follows reset
	assign haltN = resetN;

endmodule

//--- verilog/pixelMixer.sv
// Pixel mixer that picks fix, sprite, blanking or CPU address for the palette bus
`timescale 1ns/1ps

module pixelMixer (
	input  logic                      CLK_1MB,
	input  logic                      rstN,
	input  logic [7:0]                fixd,
	input  logic                      pck1,
	input  logic [3:0]                pbusFixPal,
	input  logic                      s1h1,
	input  logic                      tms0,
	input  logic                      chbl,
	input  videoPkg::lbEntry          readouts [videoPkg::lbCount],
	input  logic                      asN,
	input  logic                      a23i,
	input  logic                      a22i,
	input  logic [12:1]               addrL,
	output logic [videoPkg::paW-1:0]  pa
);
	import videoPkg::*;

	// Two fix pixels
	logic [7:0] fixReg;
	// Fix palette number
	logic [fixPalW-1:0] fixPal;
	// Fix pixel of the current half
	logic [colorW-1:0] fixColor;
	logic fixOpaque;

	// Readout of the buffer being displayed
	lbEntry sprSel;

	// Mixed and registered video address
	logic [paW-1:0] mixAddr;
	logic [paW-1:0] paVideo;

	// CPU strobe history and access flag
	logic asPrev;
	logic cpuAccess;

	// Fix byte, reloaded every cycle
	always_ff @(posedge CLK_1MB) begin
		fixReg <= fixd;
	end

	// Fix palette latch
	always_ff @(posedge CLK_1MB) begin
		if (pck1) begin
			fixPal <= pbusFixPal;
		end
	end

	// Odd pixel in the high nibble
	assign fixColor  = s1h1 ? fixReg[7:4] : fixReg[3:0];
	assign fixOpaque = (fixColor != '0);

	// Buffer select
	// tms0 swaps bottom and top, s1h1 picks left or right
	always_comb begin
		case ({tms0, s1h1})
			2'b00:   sprSel = readouts[1];
			2'b01:   sprSel = readouts[0];
			2'b10:   sprSel = readouts[3];
			default: sprSel = readouts[2];
		endcase
	end

	// Priority mix
	always_comb begin
		if (chbl) begin
			// Blanking forces palette entry 0
			mixAddr = '0;
		end else if (fixOpaque) begin
			mixAddr = {{fixPadW{1'b0}}, fixPal, fixColor};
		end else begin
			mixAddr = sprSel;
		end
	end

	// Video address register
	always_ff @(posedge CLK_1MB or negedge rstN) begin
		if (!rstN) begin
			paVideo <= '0;
		end else begin
			paVideo <= mixAddr;
		end
	end

	// CPU palette access decode
	// Evaluated on the falling edge of asN only
	always_ff @(posedge CLK_1MB or negedge rstN) begin
		if (!rstN) begin
			asPrev    <= 1'b1;
			cpuAccess <= 1'b0;
		end else begin
			asPrev <= asN;
			if (!asN && asPrev) begin
				cpuAccess <= ({a23i, a22i} == cpuPalSel);
			end
		end
	end

	// CPU owns the bus during its access
	assign pa = cpuAccess ? addrL : paVideo;

endmodule

//--- verilog/videoPkg.sv
// Video package with line buffer geometry, palette widths and watchdog constants
package videoPkg;

	// Line buffer geometry
	localparam int lbAddrW = 8;
	localparam int lbDepth = 1 << lbAddrW;
	// Buffers per chip, bottom and top pairs
	localparam int lbCount = 4;

	// Color index of a sprite or fix pixel, 0 is transparent
	localparam int colorW = 4;
	// Sprite palette number
	localparam int palW = 8;
	// Fix palette number
	localparam int fixPalW = 4;
	// Palette address bus
	localparam int paW = 12;
	// Zero bits above a fix address
	localparam int fixPadW = paW - fixPalW - colorW;

	// Idle cycles before the watchdog fires
	localparam int wdLimit = 1024;
	localparam int wdCntW = $clog2(wdLimit + 1);
	// Reset pulse length
	localparam int wdPulse = 16;
	localparam int wdPulseW = $clog2(wdPulse + 1);

	// Kick address bits 21..17, the $300000 region
	localparam logic [4:0] wdKickAddr = 5'b11000;
	// Top address lines {a23, a22} for a CPU palette access
	localparam logic [1:0] cpuPalSel = 2'b01;

	// One line buffer word
	typedef struct packed {
		logic [palW-1:0]   pal;
		logic [colorW-1:0] color;
	} lbEntry;

endpackage

//--- verilog/watchdog.sv
// CPU watchdog with decoded kick and a reset pulse aligned to the frame start
`timescale 1ns/1ps

module watchdog (
	input  logic        CLK_1MB,
	input  logic        rstN,
	input  logic        ldsN,
	input  logic        rw,
	input  logic        a23i,
	input  logic        a22i,
	input  logic [21:17] addrU,
	input  logic        bnkb,
	output logic        resetN
);
	import videoPkg::*;

	// Byte write into the kick region
	logic kick;

	// Idle cycles since the last kick, saturates at the limit
	logic [wdCntW-1:0] idleCnt;

	// Remaining cycles of the reset pulse
	logic [wdPulseW-1:0] pulseCnt;

	// Limit reached, waiting for the frame strobe
	logic armed;
	logic pulsing;

	// Kick decode
	// Low byte write with both top lines low
	assign kick = !rw && !ldsN && !a23i && !a22i && (addrU == wdKickAddr);

	assign armed   = (idleCnt == wdCntW'(wdLimit));
	assign pulsing = (pulseCnt != '0);

	// Idle counter and pulse timer
	always_ff @(posedge CLK_1MB or negedge rstN) begin
		if (!rstN) begin
			idleCnt  <= '0;
			pulseCnt <= '0;
		end else if (pulsing) begin
			pulseCnt <= pulseCnt - 1'b1;
			// Restart the count as the pulse ends
			if (pulseCnt == wdPulseW'(1)) begin
				idleCnt <= '0;
			end
		end else if (kick) begin
			idleCnt <= '0;
		end else if (armed) begin
			// Fire only at the frame strobe
			if (bnkb) begin
				pulseCnt <= wdPulseW'(wdPulse);
			end
		end else begin
			idleCnt <= idleCnt + 1'b1;
		end
	end

	// Reset held low for the whole pulse
	assign resetN = !pulsing;

endmodule
